/* battle_tanks.f */
+incdir+common
common/battle_pkg.sv
hw/frame_tick.sv
terrain/terrain_map.sv
tank/tank_motion.sv
hw/screen_painter.sv
hw/battle_top.sv
verif/battle_tb.sv

/* Makefile */
TOP = battle_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -j 0 -Wno-fatal --top-module $(TOP) -Mdir $(OBJ) -f battle_tanks.f

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	@if grep -q "Errors found" sim.log; then \
		echo "simulation FAILED"; exit 1; \
	elif ! grep -q "No errors" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ) sim.log

/* verif/battle_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "battle_macros.svh"

module battle_tb
	import battle_pkg::*;
();

	localparam int NUM_ROWS = 8;
	localparam coord_t ANY = 8'hff; // tank corner left open by the row

	typedef struct packed {
		logic [3:0] key;
		logic [7:0] frames;
		logic rand_keys; // pick right or left at random each frame
		fuel_t fuel;
		logic turn;
		coord_t t0_x;
		coord_t t0_y;
		coord_t t1_x;
		coord_t t1_y;
	} row_t;

	logic clock;
	logic rst;
	logic [3:0] key;
	coord_t pix_x, pix_y;
	colour_t pix_colour;
	logic plot;
	fuel_t fuel;
	logic turn;

	row_t rows [NUM_ROWS];
	int seed;
	int cycle_count;
	coord_t m_x [2]; // reference model
	coord_t m_y [2];
	fuel_t m_fuel;
	jump_t m_jump;
	logic m_turn;
	coord_t seen_x [2]; // corner of the last drawing with y as the tank's y
	coord_t seen_y [2];

	battle_top #(.FRAME_PERIOD(200)) dut (
		.clock(clock), .rst(rst), .key(key),
		.pix_x(pix_x), .pix_y(pix_y), .pix_colour(pix_colour), .plot(plot),
		.fuel(fuel), .turn(turn)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_coord(input string name, input coord_t got, input coord_t exp);
		if (got !== exp)
			stop_on_error($sformatf("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp));
	endtask

	task automatic check_colour(input string name, input colour_t got, input colour_t exp);
		if (got !== exp)
			stop_on_error($sformatf("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	task automatic check_fuel(input string name, input fuel_t got, input fuel_t exp);
		if (got !== exp)
			stop_on_error($sformatf("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	function automatic coord_t ref_height(input coord_t x);
		if ((x >= 8'd20 && x < 8'd40) || (x >= 8'd60 && x < 8'd80) || (x >= 8'd100 && x < 8'd120))
			return `HILL_HEIGHT;
		return `FLAT_HEIGHT;
	endfunction

	// one step of the active tank with active low keys
	task automatic model_step(input logic [3:0] k);
		coord_t x, y, nx, ny;
		logic moved_up;
		x = m_x[m_turn];
		y = m_y[m_turn];
		nx = x;
		ny = y;
		moved_up = 1'b0;
		if (!k[0]) begin
			m_turn = ~m_turn; // end of turn
			m_fuel = `FUEL_FULL;
			m_jump = `JUMP_FULL;
		end else if (m_fuel != 5'd0) begin
			if (k[3] && y == ref_height(x)) begin
				m_jump = `JUMP_FULL;
			end else if ((k[3] || m_jump == 4'd0) && y < ref_height(x)) begin
				ny = y + 8'd1;
				m_jump = 4'd0;
			end else if (!k[3] && m_jump != 4'd0) begin
				ny = y - 8'd1;
				m_jump = m_jump - 4'd1;
				moved_up = 1'b1;
			end
			if (!k[1] && x < `TANK_X_MAX && ref_height(x + 8'd1) >= y)
				nx = x + 8'd1;
			else if (!k[2] && x > 8'd0 && ref_height(x - 8'd1) >= y)
				nx = x - 8'd1;
			if (nx != x || moved_up)
				m_fuel = m_fuel - 5'd1;
			m_x[m_turn] = nx;
			m_y[m_turn] = ny;
		end
	endtask

	task automatic wait_for_plot();
		do @(negedge clock); while (plot !== 1'b1);
	endtask

	task automatic expect_pixel(input coord_t x, input coord_t y, input colour_t c);
		if (plot !== 1'b1)
			stop_on_error("plot went low in the middle of a drawing phase");
		check_coord("pix_x", pix_x, x);
		check_coord("pix_y", pix_y, y);
		check_colour("pix_colour", pix_colour, c);
		@(negedge clock);
	endtask

	task automatic expect_idle();
		if (plot !== 1'b0)
			stop_on_error("plot stayed high after the end of a drawing phase");
	endtask

	task automatic expect_tank(input int idx, input coord_t x, input coord_t y, input colour_t c);
		int r, col;
		seen_x[idx] = pix_x;
		seen_y[idx] = pix_y + 8'd1; // top row is y-1
		for (r = 0; r < 2; r++) begin
			for (col = 0; col < 16; col++) begin
				expect_pixel(x + coord_t'(col), y - 8'd1 + coord_t'(r), c);
			end
		end
	endtask

	// erase at the old corners, step, draw at the new ones
	task automatic run_frame(input logic [3:0] k);
		coord_t old_x0, old_y0, old_x1, old_y1;
		old_x0 = m_x[0];
		old_y0 = m_y[0];
		old_x1 = m_x[1];
		old_y1 = m_y[1];
		@(posedge clock);
		key <= k;
		model_step(k);
		wait_for_plot();
		expect_tank(0, old_x0, old_y0, `COL_SKY);
		expect_tank(1, old_x1, old_y1, `COL_SKY);
		expect_idle();
		wait_for_plot();
		expect_tank(0, m_x[0], m_y[0], `COL_TANK1);
		expect_tank(1, m_x[1], m_y[1], `COL_TANK2);
		expect_idle();
		check_fuel("fuel", fuel, m_fuel);
		check_flag("turn", turn, m_turn);
	endtask

	task automatic check_row(input int n);
		check_fuel("fuel", fuel, rows[n].fuel);
		check_flag("turn", turn, rows[n].turn);
		if (rows[n].t0_x != ANY) begin
			check_coord("pix_x of tank 0 corner", seen_x[0], rows[n].t0_x);
			check_coord("pix_y of tank 0 corner", seen_y[0], rows[n].t0_y);
		end
		if (rows[n].t1_x != ANY) begin
			check_coord("pix_x of tank 1 corner", seen_x[1], rows[n].t1_x);
			check_coord("pix_y of tank 1 corner", seen_y[1], rows[n].t1_y);
		end
	endtask

	task automatic load_table();
		// key, frames, random, fuel, turn, tank 0 x y, tank 1 x y
		rows[0] = '{4'b1111, 8'd8, 1'b0, 5'd30, 1'b0, 8'd5, 8'd117, 8'd76, 8'd110};
		rows[1] = '{4'b1101, 8'd16, 1'b0, 5'd16, 1'b0, 8'd19, 8'd117, 8'd76, 8'd110};
		rows[2] = '{4'b1110, 8'd1, 1'b0, 5'd30, 1'b1, 8'd19, 8'd117, 8'd76, 8'd110};
		rows[3] = '{4'b0101, 8'd12, 1'b0, 5'd18, 1'b1, 8'd19, 8'd117, 8'd80, 8'd102};
		rows[4] = '{4'b1111, 8'd60, 1'b1, 5'd0, 1'b1, 8'd19, 8'd117, ANY, ANY};
		rows[5] = '{4'b1101, 8'd5, 1'b0, 5'd0, 1'b1, 8'd19, 8'd117, ANY, ANY}; // no fuel left
		rows[6] = '{4'b1110, 8'd1, 1'b0, 5'd30, 1'b0, 8'd19, 8'd117, ANY, ANY};
		rows[7] = '{4'b1011, 8'd3, 1'b0, 5'd27, 1'b0, 8'd16, 8'd117, ANY, ANY};
	endtask

	initial begin : watchdog
		int frames, limit, n;
		@(negedge rst);
		frames = 0;
		for (n = 0; n < NUM_ROWS; n++)
			frames = frames + int'(rows[n].frames);
		limit = 19200 + 19200 + frames * 260 + 1000;
		cycle_count = 0;
		while (cycle_count < limit) begin
			@(posedge clock);
			cycle_count = cycle_count + 1;
		end
		stop_on_error($sformatf("timeout: the test table did not finish in %0d cycles", limit));
	end

	initial begin : main
		int n, f, x, y, r;
		logic [3:0] k;
		seed = 32'h5259_aec8;
		load_table();
		key = 4'b1111;
		rst = 1'b1;
		m_x[0] = `TANK1_X0;
		m_y[0] = `TANK_Y0;
		m_x[1] = `TANK2_X0;
		m_y[1] = `TANK_Y0;
		m_fuel = `FUEL_FULL;
		m_jump = `JUMP_FULL;
		m_turn = 1'b0;
		repeat (4) @(posedge clock);
		rst <= 1'b0;

		// clear, map and first drawing run back to back
		wait_for_plot();
		for (y = 0; y < 120; y++)
			for (x = 0; x < 160; x++)
				expect_pixel(coord_t'(x), coord_t'(y), `COL_SKY);
		for (y = 0; y < 120; y++)
			for (x = 0; x < 160; x++)
				expect_pixel(coord_t'(x), coord_t'(y),
					(coord_t'(y) > ref_height(coord_t'(x))) ? `COL_GROUND : `COL_SKY);
		expect_tank(0, `TANK1_X0, `TANK_Y0, `COL_TANK1);
		expect_tank(1, `TANK2_X0, `TANK_Y0, `COL_TANK2);
		expect_idle();

		for (n = 0; n < NUM_ROWS; n++) begin
			for (f = 0; f < int'(rows[n].frames); f++) begin
				k = rows[n].key;
				if (rows[n].rand_keys) begin
					r = $random(seed);
					k = r[0] ? 4'b1101 : 4'b1011;
				end
				run_frame(k);
			end
			check_row(n);
		end

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/battle_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "battle_macros.svh"

module battle_top
	import battle_pkg::*;
#(
	parameter int FRAME_PERIOD = `FRAME_PERIOD_DEFAULT
) (
	input wire logic clock,
	input wire logic rst,
	input wire logic [3:0] key,
	output coord_t pix_x,
	output coord_t pix_y,
	output colour_t pix_colour,
	output logic plot,
	output fuel_t fuel,
	output logic turn
);

	logic frame, map_ready, step, step_done;
	coord_t paint_x, paint_height, probe_x, probe_height;
	coord_t tank1_x, tank1_y, tank2_x, tank2_y;

	frame_tick #(.FRAME_PERIOD(FRAME_PERIOD)) u_frame_tick (
		.clock(clock), .rst(rst), .frame(frame)
	);

	terrain_map u_terrain_map (
		.clock(clock), .rst(rst), .map_ready(map_ready),
		.paint_x(paint_x), .paint_height(paint_height),
		.probe_x(probe_x), .probe_height(probe_height)
	);

	tank_motion u_tank_motion (
		.clock(clock), .rst(rst), .key(key), .step(step), .step_done(step_done),
		.probe_x(probe_x), .probe_height(probe_height),
		.tank1_x(tank1_x), .tank1_y(tank1_y), .tank2_x(tank2_x), .tank2_y(tank2_y),
		.fuel(fuel), .turn(turn)
	);

	screen_painter u_screen_painter (
		.clock(clock), .rst(rst), .frame(frame), .map_ready(map_ready),
		.paint_x(paint_x), .paint_height(paint_height),
		.tank1_x(tank1_x), .tank1_y(tank1_y), .tank2_x(tank2_x), .tank2_y(tank2_y),
		.step(step), .step_done(step_done),
		.pix_x(pix_x), .pix_y(pix_y), .pix_colour(pix_colour), .plot(plot)
	);

endmodule

`default_nettype wire

/* hw/screen_painter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "battle_macros.svh"

module screen_painter
	import battle_pkg::*;
(
	input wire logic clock,
	input wire logic rst,
	input wire logic frame,
	input wire logic map_ready,
	output coord_t paint_x,
	input wire coord_t paint_height,
	input wire coord_t tank1_x,
	input wire coord_t tank1_y,
	input wire coord_t tank2_x,
	input wire coord_t tank2_y,
	output logic step,
	input wire logic step_done,
	output coord_t pix_x,
	output coord_t pix_y,
	output colour_t pix_colour,
	output logic plot
);

	painter_state_t state;
	coord_t cx, cy; // column and row of the pixel counter
	logic tsel; // which tank is being walked
	coord_t nxt_cx, nxt_cy;
	logic full_screen, row_end, screen_last, tank_last;
	coord_t tx, ty;
	coord_t sel_x, sel_y;
	colour_t sel_colour;
	logic painting;
	colour_t colour_q;
	logic map_q; // pixel in flight takes its colour from the ram

	assign paint_x = cx;
	assign tx = tsel ? tank2_x : tank1_x;
	assign ty = tsel ? tank2_y : tank1_y;

	always_comb begin
		full_screen = (state == CLEAR) || (state == PAINT_MAP);
		row_end = full_screen ? (cx == `SCREEN_W - 8'd1) : (cx == `TANK_W - 8'd1);
		nxt_cx = row_end ? 8'd0 : cx + 8'd1;
		nxt_cy = row_end ? cy + 8'd1 : cy;
		screen_last = (cx == `SCREEN_W - 8'd1) && (cy == `SCREEN_H - 8'd1);
		tank_last = (cx == `TANK_W - 8'd1) && (cy == `TANK_H - 8'd1);
	end

	always_comb begin
		sel_x = cx;
		sel_y = cy;
		sel_colour = `COL_SKY;
		painting = 1'b0;
		case (state)
			CLEAR: painting = 1'b1;
			PAINT_MAP: painting = map_ready;
			DRAW_TANKS, DRAW, ERASE: begin
				sel_x = tx + cx;
				sel_y = ty - 8'd1 + cy; // top row is y-1
				painting = 1'b1;
				if (state != ERASE) sel_colour = tsel ? `COL_TANK2 : `COL_TANK1;
			end
			default: painting = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= CLEAR;
			cx <= 8'd0;
			cy <= 8'd0;
			tsel <= 1'b0;
			step <= 1'b0;
		end else begin
			step <= 1'b0;
			case (state)
				CLEAR, PAINT_MAP: begin
					if (state == CLEAR || map_ready) begin
						if (screen_last) begin
							state <= (state == CLEAR) ? PAINT_MAP : DRAW_TANKS;
							cx <= 8'd0;
							cy <= 8'd0;
						end else begin
							cx <= nxt_cx;
							cy <= nxt_cy;
						end
					end
				end
				DRAW_TANKS, ERASE, DRAW: begin
					if (tank_last) begin
						cx <= 8'd0;
						cy <= 8'd0;
						tsel <= ~tsel;
						if (tsel) begin // both tanks done
							state <= (state == ERASE) ? STEP : WAIT_FRAME;
							step <= (state == ERASE);
						end
					end else begin
						cx <= nxt_cx;
						cy <= nxt_cy;
					end
				end
				WAIT_FRAME: if (frame) state <= ERASE;
				STEP: if (step_done) state <= DRAW;
				default: state <= CLEAR;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			plot <= 1'b0;
			map_q <= 1'b0;
		end else begin
			plot <= painting;
			map_q <= (state == PAINT_MAP);
		end
	end

	always_ff @(posedge clock) begin
		pix_x <= sel_x;
		pix_y <= sel_y;
		colour_q <= sel_colour;
	end

	// ground below the column height, sky above
	assign pix_colour = map_q ? ((pix_y > paint_height) ? `COL_GROUND : `COL_SKY) : colour_q;

endmodule

`default_nettype wire

/* tank/tank_motion.sv */
`timescale 1ns/10ps
`default_nettype none

`include "battle_macros.svh"

module tank_motion
	import battle_pkg::*;
(
	input wire logic clock,
	input wire logic rst,
	input wire logic [3:0] key,
	input wire logic step,
	output logic step_done,
	output coord_t probe_x,
	input wire coord_t probe_height,
	output coord_t tank1_x,
	output coord_t tank1_y,
	output coord_t tank2_x,
	output coord_t tank2_y,
	output fuel_t fuel,
	output logic turn
);

	logic [2:0] phase; // 0 idle, 1..3 height fetch, 4 update
	jump_t jump_cap;
	coord_t cur_x, cur_y;
	coord_t h_here, h_right;
	coord_t nx, ny;
	jump_t njump;
	fuel_t nfuel;
	logic moved_up;
	logic fire_key, right_key, left_key, jump_key;

	assign fire_key = ~key[0]; // keys are active low
	assign right_key = ~key[1];
	assign left_key = ~key[2];
	assign jump_key = ~key[3];

	assign cur_x = turn ? tank2_x : tank1_x;
	assign cur_y = turn ? tank2_y : tank1_y;
	assign step_done = (phase == 3'd4);

	// address for the height arriving one phase later
	always_comb begin
		case (phase)
			3'd2: probe_x = cur_x + 8'd1;
			3'd3: probe_x = (cur_x == 8'd0) ? cur_x : cur_x - 8'd1;
			default: probe_x = cur_x;
		endcase
	end

	// probe_height holds the left neighbour during phase 4
	always_comb begin
		ny = cur_y;
		njump = jump_cap;
		moved_up = 1'b0;
		if (!jump_key && cur_y == h_here) begin
			njump = `JUMP_FULL; // standing on the ground
		end else if ((!jump_key || jump_cap == 4'd0) && cur_y < h_here) begin
			ny = cur_y + 8'd1; // falling
			njump = 4'd0;
		end else if (jump_key && jump_cap != 4'd0) begin
			ny = cur_y - 8'd1;
			njump = jump_cap - 4'd1;
			moved_up = 1'b1;
		end

		nx = cur_x;
		if (right_key && cur_x < `TANK_X_MAX && h_right >= cur_y) begin
			nx = cur_x + 8'd1;
		end else if (left_key && cur_x > 8'd0 && probe_height >= cur_y) begin
			nx = cur_x - 8'd1;
		end

		nfuel = (nx != cur_x || moved_up) ? fuel - 5'd1 : fuel; // one unit per step
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			phase <= 3'd0;
		end else if (phase == 3'd0) begin
			phase <= step ? 3'd1 : 3'd0;
		end else begin
			phase <= (phase == 3'd4) ? 3'd0 : phase + 3'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (phase == 3'd2) h_here <= probe_height;
		if (phase == 3'd3) h_right <= probe_height;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			turn <= 1'b0;
			fuel <= `FUEL_FULL;
			jump_cap <= `JUMP_FULL;
			tank1_x <= `TANK1_X0;
			tank1_y <= `TANK_Y0;
			tank2_x <= `TANK2_X0;
			tank2_y <= `TANK_Y0;
		end else if (phase == 3'd4) begin
			if (fire_key) begin
				turn <= ~turn; // end of turn
				fuel <= `FUEL_FULL;
				jump_cap <= `JUMP_FULL;
			end else if (fuel != 5'd0) begin
				jump_cap <= njump;
				fuel <= nfuel;
				if (turn) begin
					tank2_x <= nx;
					tank2_y <= ny;
				end else begin
					tank1_x <= nx;
					tank1_y <= ny;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* terrain/terrain_map.sv */
`timescale 1ns/10ps
`default_nettype none

`include "battle_macros.svh"

module terrain_map
	import battle_pkg::*;
(
	input wire logic clock,
	input wire logic rst,
	output logic map_ready,
	input wire coord_t paint_x,
	output coord_t paint_height,
	input wire coord_t probe_x,
	output coord_t probe_height
);

	coord_t height_mem [0:159];
	coord_t build_x;
	coord_t build_height;
	logic in_hill;

	// three flat-topped hills on a flat floor
	always_comb begin
		in_hill = ((build_x >= `HILL1_LO) && (build_x < `HILL1_HI)) ||
			((build_x >= `HILL2_LO) && (build_x < `HILL2_HI)) ||
			((build_x >= `HILL3_LO) && (build_x < `HILL3_HI));
		build_height = in_hill ? `HILL_HEIGHT : `FLAT_HEIGHT;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			build_x <= '0;
			map_ready <= 1'b0;
		end else if (!map_ready) begin
			if (build_x == `SCREEN_W - 8'd1) begin
				map_ready <= 1'b1; // last column written this cycle
			end else begin
				build_x <= build_x + 8'd1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!map_ready && !rst) begin
			height_mem[build_x] <= build_height;
		end
	end

	// two read ports with one cycle latency
	always_ff @(posedge clock) begin
		paint_height <= height_mem[paint_x];
		probe_height <= height_mem[probe_x];
	end

endmodule

`default_nettype wire

/* hw/frame_tick.sv */
`timescale 1ns/10ps
`default_nettype none

`include "battle_macros.svh"

module frame_tick #(
	parameter int FRAME_PERIOD = `FRAME_PERIOD_DEFAULT
) (
	input wire logic clock,
	input wire logic rst,
	output logic frame
);

	localparam int CW = $clog2(FRAME_PERIOD + 1);

	logic [CW-1:0] count;

	always_ff @(posedge clock) begin
		if (rst) begin
			count <= CW'(FRAME_PERIOD - 1);
			frame <= 1'b0;
		end else if (count == '0) begin
			count <= CW'(FRAME_PERIOD - 1); // reload
			frame <= 1'b1;
		end else begin
			count <= count - 1'b1;
			frame <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* common/battle_pkg.sv */
`default_nettype none

package battle_pkg;

	typedef logic [7:0] coord_t; // screen x or y, or ground height
	typedef logic [2:0] colour_t; // one bit each for red, green and blue
	typedef logic [4:0] fuel_t;
	typedef logic [3:0] jump_t;

	// clear and map run once after reset
	typedef enum logic [2:0] {
		CLEAR,
		PAINT_MAP,
		DRAW_TANKS,
		WAIT_FRAME,
		ERASE,
		STEP,
		DRAW
	} painter_state_t;

endpackage

`default_nettype wire

/* common/battle_macros.svh */
`ifndef BATTLE_MACROS_SVH
`define BATTLE_MACROS_SVH

`define SCREEN_W 8'd160
`define SCREEN_H 8'd120

`define TANK_W 8'd16
`define TANK_H 8'd2
`define TANK_X_MAX 8'd144 // last x where the whole tank still fits
`define TANK1_X0 8'd5
`define TANK2_X0 8'd76
`define TANK_Y0 8'd110

`define FLAT_HEIGHT 8'd117
`define HILL_HEIGHT 8'd102
`define HILL1_LO 8'd20 // hill spans include lo, exclude hi
`define HILL1_HI 8'd40
`define HILL2_LO 8'd60
`define HILL2_HI 8'd80
`define HILL3_LO 8'd100
`define HILL3_HI 8'd120

`define FUEL_FULL 5'd30
`define JUMP_FULL 4'd10

`define COL_SKY 3'b000
`define COL_GROUND 3'b111
`define COL_TANK1 3'b010
`define COL_TANK2 3'b001

`define FRAME_PERIOD_DEFAULT 833333 // 60 Hz from 50 MHz

`endif
